// ==== include/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data memory geometry, 1024 words.
`define MEM_AW          10
`define MEM_BASE        32'h0000_0000
`define MEM_BYTES       (32'h1 << (`MEM_AW + 2))
`define UNCACHED_BASE   32'h0000_0C00

`define OP_CREDITS      2   // Op buffer depth.
`define FETCH_CREDITS   1

`define REG_IDX_W       5

`endif

// ==== hdl/mem_pkg.sv ====
`include "mem_params.svh"

package mem_pkg;

    typedef logic [31:0]              u32_t;
    typedef logic [`REG_IDX_W-1:0]    reg_idx_t;
    typedef logic [3:0]               byte_en_t;
    typedef logic [`MEM_AW-1:0]       word_addr_t;

    // Access size of a load or store.
    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } byte_type_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'b00,
        EXC_ALE  = 2'b01,   // Misaligned access.
        EXC_ADE  = 2'b10    // Address out of range.
    } excp_e;

    // Memory attribute, cached or uncached.
    typedef enum logic {
        MAT_CC = 1'b0,
        MAT_UC = 1'b1
    } mat_e;

    typedef enum logic {
        LAST_DATA  = 1'b0,
        LAST_FETCH = 1'b1
    } rr_state_e;

endpackage

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/100ps

// One memory peer towards the arbiter.
interface mem_req_if import mem_pkg::*; ();

    logic       req;
    logic       we;
    word_addr_t addr;
    byte_en_t   be;
    u32_t       wdata;
    logic       gnt;
    u32_t       rdata;   // Valid one cycle after gnt on a read.

    modport peer (
        output req, we, addr, be, wdata,
        input  gnt, rdata
    );

    modport arb (
        input  req, we, addr, be, wdata,
        output gnt, rdata
    );

endinterface

// ==== hdl/addr_check.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module addr_check import mem_pkg::*; (
    input  u32_t       va_i,
    input  byte_type_e size_i,
    output excp_e      excp_o,
    output mat_e       mat_o,
    output word_addr_t waddr_o
);

    u32_t offset;
    logic misalign;
    logic out_of_range;

    // Direct mapping, physical equals virtual.
    assign offset = va_i - `MEM_BASE;
    assign out_of_range = (va_i < `MEM_BASE) || (offset >= `MEM_BYTES);

    always_comb begin
        unique case (size_i)
            HALF_WORD: misalign = va_i[0];
            WORD:      misalign = |va_i[1:0];
            default:   misalign = 1'b0;
        endcase
    end

    // Alignment wins over range.
    always_comb begin
        if (misalign) begin
            excp_o = EXC_ALE;
        end else if (out_of_range) begin
            excp_o = EXC_ADE;
        end else begin
            excp_o = EXC_NONE;
        end
    end

    assign mat_o = (va_i >= `UNCACHED_BASE) ? MAT_UC : MAT_CC;
    assign waddr_o = offset[`MEM_AW+1:2];

endmodule

// ==== hdl/mem1_stage.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module mem1_stage import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_valid_i,
    input  logic       op_is_mem_i,
    input  logic       op_is_store_i,
    input  logic       op_is_signed_i,
    input  byte_type_e op_size_i,
    input  u32_t       op_va_i,
    input  u32_t       op_wdata_i,
    input  reg_idx_t   op_rd_i,
    input  logic       op_wr_rd_i,
    output logic       op_credit_o,
    mem_req_if.peer    mem,
    output logic       fwd_valid_o,
    output reg_idx_t   fwd_idx_o,
    output u32_t       fwd_data_o,
    output logic       fwd_data_ready_o,
    output logic       wb_valid_o,
    output reg_idx_t   wb_rd_o,
    output logic       wb_we_o,
    output u32_t       wb_data_o,
    output excp_e      wb_excp_o,
    output mat_e       wb_mat_o
);

    localparam int PTR_W = $clog2(`OP_CREDITS);
    localparam int LAST  = `OP_CREDITS - 1;

    logic       buf_is_mem    [`OP_CREDITS];
    logic       buf_is_store  [`OP_CREDITS];
    logic       buf_is_signed [`OP_CREDITS];
    byte_type_e buf_size      [`OP_CREDITS];
    u32_t       buf_va        [`OP_CREDITS];
    u32_t       buf_wdata     [`OP_CREDITS];
    reg_idx_t   buf_rd        [`OP_CREDITS];
    logic       buf_wr_rd     [`OP_CREDITS];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             head_valid, head_load, retire;
    excp_e            chk_excp, head_excp;
    mat_e             chk_mat;
    word_addr_t       head_waddr;
    u32_t             st_word, ld_word;
    byte_en_t         st_be;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;

    logic       wb_load_q, wb_signed_q;
    byte_type_e wb_size_q;
    logic [1:0] wb_lane_q;
    u32_t       wb_data_q;

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            buf_is_mem[wr_ptr]    <= op_is_mem_i;
            buf_is_store[wr_ptr]  <= op_is_store_i;
            buf_is_signed[wr_ptr] <= op_is_signed_i;
            buf_size[wr_ptr]      <= op_size_i;
            buf_va[wr_ptr]        <= op_va_i;
            buf_wdata[wr_ptr]     <= op_wdata_i;
            buf_rd[wr_ptr]        <= op_rd_i;
            buf_wr_rd[wr_ptr]     <= op_wr_rd_i;
        end
    end

    // Upstream credits keep the buffer from overflowing.
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (op_valid_i) wr_ptr <= (wr_ptr == PTR_W'(LAST)) ? '0 : wr_ptr + 1'b1;
            if (retire)     rd_ptr <= (rd_ptr == PTR_W'(LAST)) ? '0 : rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(op_valid_i) - (PTR_W+1)'(retire);
        end
    end

    assign head_valid = (count != '0);

    addr_check u_addr_check (
        .va_i    (buf_va[rd_ptr]),
        .size_i  (buf_size[rd_ptr]),
        .excp_o  (chk_excp),
        .mat_o   (chk_mat),
        .waddr_o (head_waddr)
    );

    assign head_excp = buf_is_mem[rd_ptr] ? chk_excp : EXC_NONE;
    assign head_load = buf_is_mem[rd_ptr] & ~buf_is_store[rd_ptr];

    // Store data onto its byte lanes.
    always_comb begin
        st_word = buf_wdata[rd_ptr];
        st_be   = 4'b1111;
        unique case (buf_size[rd_ptr])
            BYTE: begin
                st_word[8*buf_va[rd_ptr][1:0] +: 8] = buf_wdata[rd_ptr][7:0];
                st_be = 4'b0001 << buf_va[rd_ptr][1:0];
            end
            HALF_WORD: begin
                st_word[16*buf_va[rd_ptr][1] +: 16] = buf_wdata[rd_ptr][15:0];
                st_be = buf_va[rd_ptr][1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    assign mem.req   = head_valid & buf_is_mem[rd_ptr] & (head_excp == EXC_NONE);
    assign mem.we    = buf_is_store[rd_ptr];
    assign mem.addr  = head_waddr;
    assign mem.be    = st_be;
    assign mem.wdata = st_word;

    // Non-memory ops leave after one cycle at the head.
    assign retire = head_valid & (~buf_is_mem[rd_ptr] | (head_excp != EXC_NONE) | mem.gnt);

    assign fwd_valid_o      = head_valid & buf_wr_rd[rd_ptr] & (buf_rd[rd_ptr] != '0);
    assign fwd_idx_o        = buf_rd[rd_ptr];
    assign fwd_data_o       = buf_va[rd_ptr];
    assign fwd_data_ready_o = ~head_load;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            wb_valid_o  <= 1'b0;
            wb_we_o     <= 1'b0;
            op_credit_o <= 1'b0;
        end else begin
            wb_valid_o  <= retire;
            wb_we_o     <= retire & buf_wr_rd[rd_ptr] & (head_excp == EXC_NONE);
            op_credit_o <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wb_rd_o     <= buf_rd[rd_ptr];
            wb_excp_o   <= head_excp;
            wb_mat_o    <= buf_is_mem[rd_ptr] ? chk_mat : MAT_CC;
            wb_load_q   <= head_load & (head_excp == EXC_NONE);
            wb_signed_q <= buf_is_signed[rd_ptr];
            wb_size_q   <= buf_size[rd_ptr];
            wb_lane_q   <= buf_va[rd_ptr][1:0];
            wb_data_q   <= (buf_is_mem[rd_ptr] & buf_is_store[rd_ptr]) ? st_word : buf_va[rd_ptr];
        end
    end

    // Pick the lane of the read word and extend it.
    always_comb begin
        ld_byte = mem.rdata[8*wb_lane_q +: 8];
        ld_half = mem.rdata[16*wb_lane_q[1] +: 16];
        unique case (wb_size_q)
            BYTE:      ld_word = {{24{wb_signed_q & ld_byte[7]}}, ld_byte};
            HALF_WORD: ld_word = {{16{wb_signed_q & ld_half[15]}}, ld_half};
            default:   ld_word = mem.rdata;
        endcase
    end

    assign wb_data_o = wb_load_q ? ld_word : wb_data_q;

endmodule

// ==== hdl/fetch_port.sv ====
`timescale 1ns/100ps

module fetch_port import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_valid_i,
    input  word_addr_t fetch_addr_i,
    output logic       fetch_credit_o,
    output logic       fetch_rsp_valid_o,
    output u32_t       fetch_rsp_data_o,
    mem_req_if.peer    mem
);

    logic       pend_valid;
    word_addr_t pend_addr;
    logic       rsp_q;

    // One read in flight, held until the arbiter grants it.
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            pend_valid <= 1'b0;
            rsp_q      <= 1'b0;
        end else begin
            pend_valid <= fetch_valid_i | (pend_valid & ~mem.gnt);
            rsp_q      <= pend_valid & mem.gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            pend_addr <= fetch_addr_i;
        end
    end

    assign mem.req   = pend_valid;
    assign mem.we    = 1'b0;   // Read only peer.
    assign mem.addr  = pend_addr;
    assign mem.be    = 4'b1111;
    assign mem.wdata = '0;

    // The word comes back with the credit.
    assign fetch_rsp_valid_o = rsp_q;
    assign fetch_credit_o    = rsp_q;
    assign fetch_rsp_data_o  = mem.rdata;

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    mem_req_if.arb     data_p,
    mem_req_if.arb     fetch_p,
    output logic       sram_en_o,
    output logic       sram_we_o,
    output word_addr_t sram_addr_o,
    output byte_en_t   sram_be_o,
    output u32_t       sram_wdata_o,
    input  u32_t       sram_rdata_i
);

    rr_state_e last_q;
    logic      gnt_data, gnt_fetch;

    // Round robin, the loser of the last contest goes first.
    assign gnt_data  = data_p.req & (~fetch_p.req | (last_q == LAST_FETCH));
    assign gnt_fetch = fetch_p.req & ~gnt_data;

    assign data_p.gnt  = gnt_data;
    assign fetch_p.gnt = gnt_fetch;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            last_q <= LAST_FETCH;   // Data side wins the first tie.
        end else if (gnt_data) begin
            last_q <= LAST_DATA;
        end else if (gnt_fetch) begin
            last_q <= LAST_FETCH;
        end
    end

    always_comb begin
        sram_en_o = gnt_data | gnt_fetch;
        if (gnt_fetch) begin
            sram_we_o    = fetch_p.we;
            sram_addr_o  = fetch_p.addr;
            sram_be_o    = fetch_p.be;
            sram_wdata_o = fetch_p.wdata;
        end else begin
            sram_we_o    = data_p.we;
            sram_addr_o  = data_p.addr;
            sram_be_o    = data_p.be;
            sram_wdata_o = data_p.wdata;
        end
    end

    // The cycle after a grant, last_q still names that winner.
    assign data_p.rdata  = (last_q == LAST_DATA)  ? sram_rdata_i : '0;
    assign fetch_p.rdata = (last_q == LAST_FETCH) ? sram_rdata_i : '0;

endmodule

// ==== hdl/data_sram.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module data_sram import mem_pkg::*; (
    input  logic       clk,
    input  logic       en_i,
    input  logic       we_i,
    input  word_addr_t addr_i,
    input  byte_en_t   be_i,
    input  u32_t       wdata_i,
    output u32_t       rdata_o
);

    localparam int DEPTH = 1 << `MEM_AW;

    u32_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) begin
                        mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[addr_i];   // Read data holds until next read.
            end
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_valid_i,
    input  logic       op_is_mem_i,
    input  logic       op_is_store_i,
    input  logic       op_is_signed_i,
    input  byte_type_e op_size_i,
    input  u32_t       op_va_i,
    input  u32_t       op_wdata_i,
    input  reg_idx_t   op_rd_i,
    input  logic       op_wr_rd_i,
    output logic       op_credit_o,
    output logic       fwd_valid_o,
    output reg_idx_t   fwd_idx_o,
    output u32_t       fwd_data_o,
    output logic       fwd_data_ready_o,
    output logic       wb_valid_o,
    output reg_idx_t   wb_rd_o,
    output logic       wb_we_o,
    output u32_t       wb_data_o,
    output excp_e      wb_excp_o,
    output mat_e       wb_mat_o,
    input  logic       fetch_valid_i,
    input  word_addr_t fetch_addr_i,
    output logic       fetch_credit_o,
    output logic       fetch_rsp_valid_o,
    output u32_t       fetch_rsp_data_o
);

    mem_req_if data_if ();
    mem_req_if fetch_if ();

    logic       sram_en, sram_we;
    word_addr_t sram_addr;
    byte_en_t   sram_be;
    u32_t       sram_wdata, sram_rdata;

    mem1_stage u_mem1 (.mem(data_if.peer), .*);

    fetch_port u_fetch (.mem(fetch_if.peer), .*);

    mem_arbiter u_arb (
        .clk, .rst_n,
        .data_p       (data_if.arb),
        .fetch_p      (fetch_if.arb),
        .sram_en_o    (sram_en),
        .sram_we_o    (sram_we),
        .sram_addr_o  (sram_addr),
        .sram_be_o    (sram_be),
        .sram_wdata_o (sram_wdata),
        .sram_rdata_i (sram_rdata)
    );

    data_sram u_sram (
        .clk,
        .en_i    (sram_en),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .be_i    (sram_be),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

endmodule

// ==== verif/mem_subsys_sva.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_subsys_sva (
    input logic clk,
    input logic rst_n,
    input logic op_valid_i,
    input logic op_credit_o,
    input logic fetch_credit_o,
    input logic data_req,
    input logic fetch_req,
    input logic data_gnt,
    input logic fetch_gnt
);

    int   outstanding;
    int   fail_count = 0;
    logic seen_win, fetch_won;

    // Ops sent minus credits returned, as seen upstream.
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(op_valid_i) - int'(op_credit_o);
        end
    end

    // Last winner, tracked apart from the arbiter.
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            seen_win  <= 1'b0;
            fetch_won <= 1'b0;
        end else if (data_gnt || fetch_gnt) begin
            seen_win  <= 1'b1;
            fetch_won <= fetch_gnt;
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding >= 0 && outstanding <= `OP_CREDITS)
        else begin
            $error("Outstanding ops outside the credit range");
            fail_count++;
        end

    // One grant whenever a peer asks, none when idle.
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({data_gnt, fetch_gnt}) == int'(data_req || fetch_req))
        else begin
            $error("Grant count does not match the requests");
            fail_count++;
        end

    a_rr_turn: assert property (@(posedge clk) disable iff (!rst_n)
        seen_win && data_req && fetch_req |-> (fetch_won ? data_gnt : fetch_gnt))
        else begin
            $error("Tie granted to the last winner");
            fail_count++;
        end

    a_credit_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !op_credit_o && !fetch_credit_o)
        else begin
            $error("Credit output high right after reset");
            fail_count++;
        end

endmodule

bind mem_subsys_top mem_subsys_sva sva_i (
    .clk,
    .rst_n,
    .op_valid_i,
    .op_credit_o,
    .fetch_credit_o,
    .data_req  (data_if.req),
    .fetch_req (fetch_if.req),
    .data_gnt  (data_if.gnt),
    .fetch_gnt (fetch_if.gnt)
);

// ==== verif/mem_subsys_checker.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_subsys_checker import mem_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       op_valid_i,
    input logic       op_is_mem_i,
    input logic       op_is_store_i,
    input byte_type_e op_size_i,
    input u32_t       op_va_i,
    input u32_t       op_wdata_i,
    input reg_idx_t   op_rd_i,
    input logic       op_wr_rd_i,
    input logic       fwd_valid_o,
    input reg_idx_t   fwd_idx_o,
    input u32_t       fwd_data_o,
    input logic       fwd_data_ready_o,
    input logic       wb_valid_o,
    input reg_idx_t   wb_rd_o,
    input logic       wb_we_o,
    input u32_t       wb_data_o,
    input excp_e      wb_excp_o,
    input mat_e       wb_mat_o,
    input logic       fetch_valid_i,
    input word_addr_t fetch_addr_i,
    input logic       fetch_rsp_valid_o,
    input u32_t       fetch_rsp_data_o
);

    typedef struct packed {
        logic       is_mem;
        logic       is_store;
        byte_type_e size;
        u32_t       va;
        u32_t       wdata;
        reg_idx_t   rd;
        logic       wr_rd;
        u32_t       exp_data;
        excp_e      exp_excp;
    } op_rec_t;

    u32_t       model [1 << `MEM_AW];   // Unwritten words stay X.
    u32_t       exp_data_q [$];
    excp_e      exp_excp_q [$];
    op_rec_t    inflight [$];
    word_addr_t fetch_q [$];
    int         errors = 0;
    int         wb_count = 0;
    int         fetch_count = 0;

    task automatic push_expected(input u32_t data, input excp_e excp);
        exp_data_q.push_back(data);
        exp_excp_q.push_back(excp);
    endtask

    task automatic compare_val(input string name, input u32_t got, input u32_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_missing();
        if (inflight.size() != 0) begin
            $display("Write-back missing for %0d ops at end of run", inflight.size());
            errors++;
        end
        if (fetch_q.size() != 0) begin
            $display("Fetch response missing for %0d reads at end of run", fetch_q.size());
            errors++;
        end
    endtask

    task automatic check_writeback();
        op_rec_t    op;
        word_addr_t w;
        logic       ok;
        if (inflight.size() == 0) begin
            $display("Write-back at %0t with no op in flight", $time);
            errors++;
            return;
        end
        op = inflight.pop_front();
        wb_count++;
        ok = (op.exp_excp == EXC_NONE);
        w  = op.va[`MEM_AW+1:2];
        compare_val("wb_rd_o", wb_rd_o, op.rd);
        compare_val("wb_we_o", wb_we_o, op.wr_rd & ok);
        compare_val("wb_excp_o", wb_excp_o, op.exp_excp);
        compare_val("wb_mat_o", wb_mat_o,
                    (op.is_mem && op.va >= `UNCACHED_BASE) ? MAT_UC : MAT_CC);
        if (ok && !(op.is_mem && op.is_store)) begin
            compare_val("wb_data_o", wb_data_o, op.exp_data);
        end
        // Stores land on lanes picked by the low address bits.
        if (ok && op.is_mem && op.is_store) begin
            case (op.size)
                BYTE:      model[w][8*op.va[1:0] +: 8] = op.wdata[7:0];
                HALF_WORD: model[w][16*op.va[1] +: 16] = op.wdata[15:0];
                default:   model[w] = op.wdata;
            endcase
        end
    endtask

    task automatic check_forward();
        op_rec_t head;
        logic    exp_valid;
        if (inflight.size() == 0) begin
            compare_val("fwd_valid_o", fwd_valid_o, 1'b0);
            return;
        end
        head = inflight[0];
        exp_valid = head.wr_rd && (head.rd != '0);
        compare_val("fwd_valid_o", fwd_valid_o, exp_valid);
        if (exp_valid) begin
            compare_val("fwd_idx_o", fwd_idx_o, head.rd);
            compare_val("fwd_data_ready_o", fwd_data_ready_o, !(head.is_mem && !head.is_store));
            if (!head.is_mem) compare_val("fwd_data_o", fwd_data_o, head.va);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_valid_o) check_writeback();
            check_forward();
            if (fetch_rsp_valid_o) begin
                if (fetch_q.size() == 0) begin
                    $display("Fetch response at %0t with no read pending", $time);
                    errors++;
                end else begin
                    fetch_count++;
                    compare_val("fetch_rsp_data_o", fetch_rsp_data_o, model[fetch_q.pop_front()]);
                end
            end
            if (op_valid_i) begin
                if (exp_data_q.size() == 0) begin
                    $display("Op sent at %0t with no expected result", $time);
                    errors++;
                end else begin
                    inflight.push_back('{op_is_mem_i, op_is_store_i, op_size_i, op_va_i,
                                        op_wdata_i, op_rd_i, op_wr_rd_i,
                                        exp_data_q.pop_front(), exp_excp_q.pop_front()});
                end
            end
            if (fetch_valid_i) fetch_q.push_back(fetch_addr_i);
        end
    end

endmodule

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_subsys_tb import mem_pkg::*; ();

    typedef struct packed {
        logic       is_mem;
        logic       is_store;
        logic       sgn;
        byte_type_e size;
        u32_t       va;
        u32_t       wdata;
        reg_idx_t   rd;
        logic       wr_rd;
        u32_t       exp_data;
        excp_e      exp_excp;
    } row_t;

    logic       clk, rst_n;
    logic       op_valid_i, op_is_mem_i, op_is_store_i, op_is_signed_i, op_wr_rd_i;
    byte_type_e op_size_i;
    u32_t       op_va_i, op_wdata_i;
    reg_idx_t   op_rd_i;
    logic       op_credit_o, fwd_valid_o, fwd_data_ready_o, wb_valid_o, wb_we_o;
    reg_idx_t   fwd_idx_o, wb_rd_o;
    u32_t       fwd_data_o, wb_data_o;
    excp_e      wb_excp_o;
    mat_e       wb_mat_o;
    logic       fetch_valid_i, fetch_credit_o, fetch_rsp_valid_o;
    word_addr_t fetch_addr_i;
    u32_t       fetch_rsp_data_o;

    row_t rows [$];
    int   idx, op_cred, fetch_cred, cycles, limit;
    logic [31:0] rnd;
    row_t r;

    mem_subsys_top dut_i (.*);
    mem_subsys_checker chk_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Fetches aim at words the table writes.
    function automatic word_addr_t fetch_target(input logic [1:0] sel);
        case (sel)
            2'd0:    return 10'h040;
            2'd1:    return 10'h041;
            2'd2:    return 10'h042;
            default: return 10'h300;
        endcase
    endfunction

    task automatic add_row(input logic m, s, sg, input byte_type_e sz, input u32_t va, wd,
                           input reg_idx_t rd, input logic wr, input u32_t ed, input excp_e ex);
        rows.push_back('{m, s, sg, sz, va, wd, rd, wr, ed, ex});
    endtask

    task automatic print_counts();
        $display("Write-backs %0d, fetches %0d, errors %0d, assertion failures %0d",
                 chk_i.wb_count, chk_i.fetch_count, chk_i.errors, dut_i.sva_i.fail_count);
    endtask

    task automatic build_table();
        add_row(1, 1, 0, WORD,      32'h100,  32'h8765_43A1, 0,  0, 0, EXC_NONE);
        add_row(1, 0, 0, WORD,      32'h100,  0, 3,  1, 32'h8765_43A1, EXC_NONE);
        add_row(1, 1, 0, WORD,      32'h104,  32'h1122_3344, 0,  0, 0, EXC_NONE);
        add_row(1, 1, 0, BYTE,      32'h105,  32'h0000_00F0, 0,  0, 0, EXC_NONE);
        add_row(1, 0, 1, BYTE,      32'h105,  0, 4,  1, 32'hFFFF_FFF0, EXC_NONE);
        add_row(1, 0, 0, BYTE,      32'h105,  0, 5,  1, 32'h0000_00F0, EXC_NONE);
        add_row(1, 0, 0, WORD,      32'h104,  0, 6,  1, 32'h1122_F044, EXC_NONE);
        add_row(1, 1, 0, WORD,      32'h108,  0, 0,  0, 0, EXC_NONE);
        add_row(1, 1, 0, HALF_WORD, 32'h10A,  32'h0000_8001, 0,  0, 0, EXC_NONE);
        add_row(1, 0, 1, HALF_WORD, 32'h10A,  0, 7,  1, 32'hFFFF_8001, EXC_NONE);
        add_row(1, 0, 0, HALF_WORD, 32'h10A,  0, 8,  1, 32'h0000_8001, EXC_NONE);
        add_row(1, 0, 0, HALF_WORD, 32'h104,  0, 9,  1, 32'h0000_F044, EXC_NONE);
        add_row(1, 0, 1, BYTE,      32'h107,  0, 10, 1, 32'h0000_0011, EXC_NONE);
        add_row(1, 1, 0, WORD,      32'h102,  32'hDEAD_0000, 0,  0, 0, EXC_ALE);
        add_row(1, 1, 0, HALF_WORD, 32'h103,  32'h0000_BEEF, 0,  0, 0, EXC_ALE);
        add_row(1, 0, 0, WORD,      32'h106,  0, 11, 1, 0, EXC_ALE);
        add_row(1, 1, 0, WORD,      32'h1100, 32'h0BAD_0BAD, 0,  0, 0, EXC_ADE);
        add_row(1, 0, 0, WORD,      32'h1000, 0, 12, 1, 0, EXC_ADE);
        add_row(1, 0, 0, WORD,      32'h100,  0, 13, 1, 32'h8765_43A1, EXC_NONE);
        add_row(1, 1, 0, WORD,      32'hC00,  32'hCAFE_0001, 0,  0, 0, EXC_NONE);
        add_row(1, 0, 0, WORD,      32'hC00,  0, 14, 1, 32'hCAFE_0001, EXC_NONE);
        add_row(0, 0, 0, WORD,      32'h1234_5678, 0, 15, 1, 32'h1234_5678, EXC_NONE);
        add_row(0, 0, 0, WORD,      32'h55,   0, 0,  1, 32'h0000_0055, EXC_NONE);
        add_row(1, 0, 1, BYTE,      32'hC03,  0, 16, 1, 32'hFFFF_FFCA, EXC_NONE);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run still busy after %0d cycles", limit);
            print_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        {op_valid_i, op_is_mem_i, op_is_store_i, op_is_signed_i, op_wr_rd_i} = '0;
        op_size_i = WORD;
        {op_va_i, op_wdata_i, op_rd_i} = '0;
        fetch_valid_i = 1'b0;
        fetch_addr_i = '0;
        cycles = 0;
        rnd = 32'ha746;
        build_table();
        limit = 40 * rows.size() + 200;
        idx = 0;
        op_cred = `OP_CREDITS;
        fetch_cred = `FETCH_CREDITS;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (!(idx == rows.size() && op_cred == `OP_CREDITS
                 && fetch_cred == `FETCH_CREDITS)) begin
            @(posedge clk);
            op_cred += op_credit_o;
            fetch_cred += fetch_credit_o;
            if (idx < rows.size() && op_cred > 0) begin
                r = rows[idx];
                op_valid_i     <= 1'b1;
                op_is_mem_i    <= r.is_mem;
                op_is_store_i  <= r.is_store;
                op_is_signed_i <= r.sgn;
                op_size_i      <= r.size;
                op_va_i        <= r.va;
                op_wdata_i     <= r.wdata;
                op_rd_i        <= r.rd;
                op_wr_rd_i     <= r.wr_rd;
                chk_i.push_expected(r.exp_data, r.exp_excp);
                op_cred--;
                idx++;
            end else begin
                op_valid_i <= 1'b0;
            end
            rnd = xorshift(rnd);
            if (idx < rows.size() && fetch_cred > 0 && rnd[0]) begin
                fetch_valid_i <= 1'b1;
                fetch_addr_i  <= fetch_target(rnd[5:4]);
                fetch_cred--;
            end else begin
                fetch_valid_i <= 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        chk_i.report_missing();
        print_counts();
        if (chk_i.errors == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/addr_check.sv
hdl/mem1_stage.sv
hdl/fetch_port.sv
hdl/mem_arbiter.sv
hdl/data_sram.sv
hdl/mem_subsys_top.sv
verif/mem_subsys_sva.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv
